// File: vlog.f
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_stage_if.sv
verilog/dpsram.sv
verilog/dcache_lookup.sv
verilog/store_buffer.sv
verilog/dcache_hit.sv
verilog/dcache_top.sv
bench/tb_dcache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_dcache
FILELIST  = vlog.f

BIN  = obj_dir/V$(TOP)
SRCS = $(wildcard verilog/*.sv bench/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: bench/tb_dcache.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module tb_dcache
    import dcache_pkg::*;
();

    localparam int K_REFILL = 0;
    localparam int K_LOAD = 1;
    localparam int K_STORE = 2;
    localparam int K_DRAIN = 3;
    localparam int K_STALL = 4;
    localparam int K_CLOAD = 5;
    localparam int K_FLUSH = 6;

    // for refill rows data bit 0 selects the way and bit 1 sets dirty
    typedef struct {
        int          kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  size;
        logic        sgn;
        logic        hit;
    } step_t;

    typedef struct packed {
        logic [29:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  way;
    } sbm_t;

    logic clk;
    logic rst_n;
    logic flush_i;
    logic req_valid_i;
    logic req_ready_o;
    logic [31:0] req_addr_i;
    logic [31:0] req_wdata_i;
    logic [3:0] req_strb_i;
    mem_size_e req_size_i;
    logic req_signed_i;
    logic [3:0] req_id_i;
    logic resp_valid_o;
    logic resp_ready_i;
    logic [3:0] resp_id_o;
    logic resp_store_o;
    logic resp_hit_o;
    logic [31:0] resp_rdata_o;
    logic [1:0] resp_way_hit_o;
    way_idx_t resp_victim_o;
    logic resp_victim_dirty_o;
    logic [31:0] cm_addr_i;
    way_idx_t cm_way_i;
    logic cm_tag_we_i;
    dc_tag_t cm_tag_i;
    logic [3:0] cm_data_strb_i;
    logic [31:0] cm_wdata_i;
    logic [31:0] cm_rdata_o;
    logic cm_sb_pop_i;
    logic sb_head_valid_o;
    logic [29:0] sb_head_addr_o;
    logic [31:0] sb_head_data_o;
    logic [3:0] sb_head_strb_o;
    logic [1:0] sb_head_way_o;

    step_t       tbl [64];
    int          n_steps = 0;
    int          errors = 0;
    int          failed_steps = 0;
    logic [31:0] lcg_state = 32'h3df9_f6a2;
    logic [3:0]  id_ctr = '0;

    // reference model
    dc_tag_t     mtag [2][16];
    logic [31:0] mdata [2][64];
    sbm_t        sbq [$];
    logic        mvictim = 1'b0;

    dcache_top dcache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic add_step(int kind, logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                            logic [1:0] size, logic sgn, logic hit);
        tbl[n_steps] = '{kind, addr, data, strb, size, sgn, hit};
        n_steps++;
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic flag_error(string what);
        $display("** Error: %s", what);
        errors++;
    endtask

    function automatic logic [1:0] model_way_hit(logic [31:0] a);
        logic [1:0] v;
        for (int w = 0; w < 2; w++) begin
            v[w] = mtag[w][a[7:4]].valid && (mtag[w][a[7:4]].tag == a[31:8]);
        end
        return v;
    endfunction

    // RAM word of the hit way with buffered stores laid over it from oldest to youngest
    function automatic logic [31:0] model_word(logic [31:0] a);
        logic [1:0]  v;
        logic [31:0] word;
        v = model_way_hit(a);
        word = '0;
        for (int w = 0; w < 2; w++) begin
            if (v[w]) word = mdata[w][a[7:2]];
        end
        foreach (sbq[i]) begin
            for (int b = 0; b < 4; b++) begin
                if (sbq[i].addr == a[31:2] && sbq[i].strb[b]) begin
                    word[8*b +: 8] = sbq[i].data[8*b +: 8];
                end
            end
        end
        return word;
    endfunction

    function automatic logic [31:0] align_load(logic [31:0] word, logic [1:0] lo,
                                               logic [1:0] size, logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*lo +: 8];
        h = lo[1] ? word[31:16] : word[15:0];
        if (size == 2'd0) return {{24{sgn & b[7]}}, b};
        if (size == 2'd1) return {{16{sgn & h[15]}}, h};
        return word;
    endfunction

    // invalidate every tag so that misses are defined
    task automatic clear_tags();
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 2; w++) begin
                cm_addr_i = s << 4;
                cm_way_i = way_idx_t'(w);
                cm_tag_i = '0;
                cm_tag_we_i = 1'b1;
                mtag[w][s] = '0;
                @(negedge clk);
            end
        end
        cm_tag_we_i = 1'b0;
    endtask

    task automatic refill(step_t s);
        logic [31:0] w;
        cm_way_i = way_idx_t'(s.data[0]);
        cm_addr_i = s.addr;
        cm_tag_i = '{1'b1, s.data[1], s.addr[31:8]};
        cm_tag_we_i = 1'b1;
        @(negedge clk);
        cm_tag_we_i = 1'b0;
        mtag[s.data[0]][s.addr[7:4]] = cm_tag_i;
        for (int k = 0; k < 4; k++) begin
            w = next_rand();
            cm_addr_i = {s.addr[31:4], k[1:0], 2'b00};
            cm_wdata_i = w;
            cm_data_strb_i = 4'hf;
            mdata[s.data[0]][cm_addr_i[7:2]] = w;
            @(negedge clk);
            cm_data_strb_i = 4'h0;
            check_val("cm_rdata_o", cm_rdata_o, w);
        end
    endtask

    task automatic drain_head();
        sbm_t e;
        if (sbq.size() == 0) begin
            flag_error("drain asked for with an empty store buffer");
            return;
        end
        e = sbq[0];
        check_val("sb_head_valid_o", sb_head_valid_o, 1);
        check_val("sb_head_addr_o", sb_head_addr_o, e.addr);
        check_val("sb_head_data_o", sb_head_data_o, e.data);
        check_val("sb_head_strb_o", sb_head_strb_o, e.strb);
        check_val("sb_head_way_o", sb_head_way_o, e.way);
        cm_addr_i = {e.addr, 2'b00};
        cm_way_i = way_idx_t'(e.way[1]);
        cm_wdata_i = e.data;
        // a store that missed is only popped
        cm_data_strb_i = (e.way != 0) ? e.strb : 4'h0;
        cm_sb_pop_i = 1'b1;
        @(posedge clk);
        for (int b = 0; b < 4; b++) begin
            if (e.way != 0 && e.strb[b]) begin
                mdata[e.way[1]][e.addr[5:0]][8*b +: 8] = e.data[8*b +: 8];
            end
        end
        void'(sbq.pop_front());
        @(negedge clk);
        cm_sb_pop_i = 1'b0;
        cm_data_strb_i = 4'h0;
    endtask

    task automatic check_resp(step_t s, logic [3:0] id, logic is_store, logic [1:0] exp_way,
                              logic [31:0] exp_data, logic exp_dirty);
        check_val("resp_valid_o", resp_valid_o, 1);
        check_val("resp_id_o", resp_id_o, id);
        check_val("resp_store_o", resp_store_o, is_store);
        check_val("resp_hit_o", resp_hit_o, s.hit);
        check_val("resp_way_hit_o", resp_way_hit_o, exp_way);
        check_val("resp_victim_o", resp_victim_o, mvictim);
        check_val("resp_victim_dirty_o", resp_victim_dirty_o, exp_dirty);
        if (!is_store && s.hit) check_val("resp_rdata_o", resp_rdata_o, exp_data);
    endtask

    task automatic do_req(step_t s);
        logic        is_store;
        logic [1:0]  exp_way;
        logic [31:0] exp_data;
        logic        exp_dirty;
        is_store = |s.strb;
        req_addr_i = s.addr;
        req_wdata_i = s.data;
        req_strb_i = s.strb;
        req_size_i = mem_size_e'(s.size);
        req_signed_i = s.sgn;
        req_id_i = id_ctr;
        req_valid_i = 1'b1;
        resp_ready_i = (s.kind != K_STALL);
        if (s.kind == K_CLOAD) begin
            // commit write to the same word on the accepting edge
            cm_addr_i = s.addr;
            cm_way_i = way_idx_t'(model_way_hit(s.addr) == 2'b10);
            cm_wdata_i = s.data;
            cm_data_strb_i = 4'hf;
        end
        while (!req_ready_o) @(negedge clk);
        @(posedge clk);
        if (s.kind == K_CLOAD) mdata[cm_way_i][s.addr[7:2]] = s.data;
        @(negedge clk);
        req_valid_i = 1'b0;
        cm_data_strb_i = 4'h0;
        if (s.kind == K_FLUSH) begin
            flush_i = 1'b1;
            #1;
            if (resp_valid_o !== 1'b0) flag_error("response still valid while flushed");
            @(negedge clk);
            flush_i = 1'b0;
            #1;
            if (resp_valid_o !== 1'b0) flag_error("flushed request came back");
            check_val("sb_head_valid_o", sb_head_valid_o, sbq.size() != 0);
            @(negedge clk);
            id_ctr++;
            return;
        end
        exp_way = model_way_hit(s.addr);
        exp_data = align_load(model_word(s.addr), s.addr[1:0], s.size, s.sgn);
        exp_dirty = mtag[mvictim][s.addr[7:4]].dirty;
        check_resp(s, id_ctr, is_store, exp_way, exp_data, exp_dirty);
        if (s.kind == K_STALL) begin
            repeat (3) begin
                @(negedge clk);
                if (req_ready_o) flag_error("request accepted while the response is held");
                check_resp(s, id_ctr, is_store, exp_way, exp_data, exp_dirty);
            end
            resp_ready_i = 1'b1;
            #1;
        end
        if (is_store && sbq.size() == `DC_SB_DEPTH) begin
            repeat (2) begin
                if (req_ready_o) flag_error("store left M1 with the store buffer full");
                @(negedge clk);
            end
            drain_head();
        end
        while (!req_ready_o) @(negedge clk);
        @(posedge clk);
        if (is_store) begin
            sbq.push_back('{s.addr[31:2], s.data, s.strb, exp_way});
        end else if (!s.hit) begin
            mvictim = !mvictim;
        end
        @(negedge clk);
        if (resp_valid_o) flag_error("response still valid after it was taken");
        id_ctr++;
    endtask

    function automatic string kind_name(int k);
        case (k)
            K_REFILL: return "refill";
            K_LOAD:   return "load";
            K_STORE:  return "store";
            K_DRAIN:  return "drain";
            K_STALL:  return "stall";
            K_CLOAD:  return "conflict load";
            default:  return "flush";
        endcase
    endfunction

    task automatic report(string name, int idx, int errs_before);
        if (errors == errs_before) begin
            $display("step %0d %s: ok", idx, name);
        end else begin
            $display("step %0d %s: failed with %0d errors", idx, name, errors - errs_before);
            failed_steps++;
        end
    endtask

    task automatic build_table();
        add_step(K_REFILL, 32'h0001_2300, 32'd0, 4'h0, 2'd2, 1'b0, 1'b0);
        add_step(K_REFILL, 32'h0004_5600, 32'd3, 4'h0, 2'd2, 1'b0, 1'b0);
        for (int k = 0; k < 4; k++) add_step(K_LOAD, 32'h0001_2300 + 4 * k, 0, 0, 2'd2, 0, 1);
        for (int o = 0; o < 4; o++) begin
            add_step(K_LOAD, 32'h0001_2304 + o, 0, 0, 2'd0, 1'b0, 1);
            add_step(K_LOAD, 32'h0001_2304 + o, 0, 0, 2'd0, 1'b1, 1);
        end
        for (int o = 0; o < 4; o += 2) begin
            add_step(K_LOAD, 32'h0004_5608 + o, 0, 0, 2'd1, 1'b0, 1);
            add_step(K_LOAD, 32'h0004_5608 + o, 0, 0, 2'd1, 1'b1, 1);
        end
        add_step(K_LOAD, 32'h0007_8900, 0, 0, 2'd2, 0, 0);
        add_step(K_LOAD, 32'h0007_8900, 0, 0, 2'd2, 0, 0);
        // these stores fill the store buffer and the last one waits for a pop
        add_step(K_STORE, 32'h0001_230a, next_rand(), 4'hc, 2'd1, 0, 1);
        add_step(K_LOAD, 32'h0001_2308, 0, 0, 2'd2, 0, 1);
        add_step(K_STORE, 32'h0001_2308, next_rand(), 4'h1, 2'd0, 0, 1);
        add_step(K_STORE, 32'h0001_2308, next_rand(), 4'h1, 2'd0, 0, 1);
        add_step(K_LOAD, 32'h0001_2308, 0, 0, 2'd0, 1, 1);
        add_step(K_STORE, 32'h0009_a010, next_rand(), 4'h4, 2'd0, 0, 0);
        add_step(K_LOAD, 32'h0009_a012, 0, 0, 2'd0, 0, 1);
        add_step(K_STORE, 32'h0004_5604, next_rand(), 4'hf, 2'd2, 0, 1);
        repeat (4) add_step(K_DRAIN, 0, 0, 0, 2'd0, 0, 0);
        add_step(K_LOAD, 32'h0001_2308, 0, 0, 2'd2, 0, 1);
        add_step(K_LOAD, 32'h0004_5604, 0, 0, 2'd2, 0, 1);
        add_step(K_CLOAD, 32'h0001_230c, next_rand(), 0, 2'd2, 0, 1);
        add_step(K_STALL, 32'h0001_2300, 0, 0, 2'd2, 0, 1);
        add_step(K_FLUSH, 32'h0001_2304, next_rand(), 4'hf, 2'd2, 0, 1);
        add_step(K_LOAD, 32'h0001_2304, 0, 0, 2'd2, 0, 1);
    endtask

    // budget grows with the table plus reset and tag clearing
    initial begin
        #1;
        repeat (16 + (n_steps + 4) * 20) @(posedge clk);
        $display("watchdog expired, the DUT stopped responding");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int e0;
        rst_n = 1'b0;
        flush_i = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i = '0;
        req_wdata_i = '0;
        req_strb_i = '0;
        req_size_i = MEM_WORD;
        req_signed_i = 1'b0;
        req_id_i = '0;
        resp_ready_i = 1'b1;
        cm_addr_i = '0;
        cm_way_i = '0;
        cm_tag_we_i = 1'b0;
        cm_tag_i = '0;
        cm_data_strb_i = '0;
        cm_wdata_i = '0;
        cm_sb_pop_i = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        e0 = errors;
        check_val("req_ready_o", req_ready_o, 1);
        check_val("resp_valid_o", resp_valid_o, 0);
        check_val("sb_head_valid_o", sb_head_valid_o, 0);
        report("reset", 0, e0);
        clear_tags();
        for (int i = 0; i < n_steps; i++) begin
            e0 = errors;
            case (tbl[i].kind)
                K_REFILL: refill(tbl[i]);
                K_DRAIN:  drain_head();
                default:  do_req(tbl[i]);
            endcase
            report(kind_name(tbl[i].kind), i + 1, e0);
        end
        $display("%0d steps, %0d failed, %0d errors", n_steps + 1, failed_steps, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush_i,
    // request
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  logic [31:0]          req_addr_i,
    input  logic [31:0]          req_wdata_i,
    input  logic [3:0]           req_strb_i,
    input  mem_size_e            req_size_i,
    input  logic                 req_signed_i,
    input  logic [3:0]           req_id_i,
    // response
    output logic                 resp_valid_o,
    input  logic                 resp_ready_i,
    output logic [3:0]           resp_id_o,
    output logic                 resp_store_o,
    output logic                 resp_hit_o,
    output logic [31:0]          resp_rdata_o,
    output logic [`DC_WAYS-1:0]  resp_way_hit_o,
    output way_idx_t             resp_victim_o,
    output logic                 resp_victim_dirty_o,
    // commit side
    input  logic [31:0]          cm_addr_i,
    input  way_idx_t             cm_way_i,
    input  logic                 cm_tag_we_i,
    input  dc_tag_t              cm_tag_i,
    input  logic [3:0]           cm_data_strb_i,
    input  logic [31:0]          cm_wdata_i,
    output logic [31:0]          cm_rdata_o,
    input  logic                 cm_sb_pop_i,
    output logic                 sb_head_valid_o,
    output logic [29:0]          sb_head_addr_o,
    output logic [31:0]          sb_head_data_o,
    output logic [3:0]           sb_head_strb_o,
    output logic [`DC_WAYS-1:0]  sb_head_way_o
);

    localparam int tag_w = $bits(dc_tag_t);

    logic [`DC_IDX_HI-`DC_IDX_LO:0]   tag_raddr;
    logic [`DC_IDX_HI-`DC_WORD_LO:0]  data_raddr;
    logic                             tag_ren;
    logic                             data_ren;
    dc_tag_t [`DC_WAYS-1:0]           tag_rdata0;
    dc_tag_t [`DC_WAYS-1:0]           tag_rdata1;
    logic [`DC_WAYS-1:0][31:0]        data_rdata0;
    logic [`DC_WAYS-1:0][31:0]        data_rdata1;

    m1_if m1 ();
    sb_if sb ();

    dcache_lookup lookup_i (
        .clk, .rst_n, .flush_i,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_wdata_i,
        .req_strb_i, .req_size_i, .req_signed_i, .req_id_i,
        .cm_addr_i,
        .tag_raddr_o(tag_raddr),
        .data_raddr_o(data_raddr),
        .tag_ren_o(tag_ren),
        .data_ren_o(data_ren),
        .m1(m1.lookup)
    );

    // commit writes use port 1 of the selected way
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        logic sel;

        assign sel = cm_way_i == way_idx_t'(w);

        dpsram #(.data_width(tag_w), .depth(`DC_SETS)) tag_ram_i (
            .clk, .rst_n,
            .addr0_i(tag_raddr),
            .en0_i(tag_ren),
            .rdata0_o(tag_rdata0[w]),
            .addr1_i(cm_addr_i[`DC_IDX_HI:`DC_IDX_LO]),
            .we1_i({((tag_w + 7) / 8){cm_tag_we_i & sel}}),
            .wdata1_i(cm_tag_i),
            .rdata1_o(tag_rdata1[w])
        );

        dpsram #(.data_width(32), .depth(`DC_SETS * `DC_LINE_WORDS)) data_ram_i (
            .clk, .rst_n,
            .addr0_i(data_raddr),
            .en0_i(data_ren),
            .rdata0_o(data_rdata0[w]),
            .addr1_i(cm_addr_i[`DC_IDX_HI:`DC_WORD_LO]),
            .we1_i(cm_data_strb_i & {4{sel}}),
            .wdata1_i(cm_wdata_i),
            .rdata1_o(data_rdata1[w])
        );
    end

    dcache_hit hit_i (
        .clk, .rst_n,
        .m1(m1.hit),
        .sb(sb.writer),
        .tag_rdata0_i(tag_rdata0),
        .tag_rdata1_i(tag_rdata1),
        .data_rdata0_i(data_rdata0),
        .data_rdata1_i(data_rdata1),
        .cm_way_i, .cm_rdata_o, .resp_ready_i,
        .resp_valid_o, .resp_id_o, .resp_store_o, .resp_hit_o,
        .resp_rdata_o, .resp_way_hit_o, .resp_victim_o, .resp_victim_dirty_o
    );

    store_buffer sb_i (
        .clk, .rst_n, .cm_sb_pop_i,
        .sb(sb.buffer),
        .sb_head_valid_o, .sb_head_addr_o, .sb_head_data_o,
        .sb_head_strb_o, .sb_head_way_o
    );

endmodule

// File: verilog/dcache_hit.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_hit
    import dcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    m1_if.hit                           m1,
    sb_if.writer                        sb,
    input  dc_tag_t [`DC_WAYS-1:0]      tag_rdata0_i,
    input  dc_tag_t [`DC_WAYS-1:0]      tag_rdata1_i,
    input  logic [`DC_WAYS-1:0][31:0]   data_rdata0_i,
    input  logic [`DC_WAYS-1:0][31:0]   data_rdata1_i,
    input  way_idx_t                    cm_way_i,
    output logic [31:0]                 cm_rdata_o,
    input  logic                        resp_ready_i,
    output logic                        resp_valid_o,
    output logic [3:0]                  resp_id_o,
    output logic                        resp_store_o,
    output logic                        resp_hit_o,
    output logic [31:0]                 resp_rdata_o,
    output logic [`DC_WAYS-1:0]         resp_way_hit_o,
    output way_idx_t                    resp_victim_o,
    output logic                        resp_victim_dirty_o
);

    m1_req_t                   req;
    dc_tag_t [`DC_WAYS-1:0]    tag_sel;
    logic [`DC_WAYS-1:0]       tag_hit;
    logic [31:0]               ram_word;
    logic [31:0]               fwd_word;
    logic [31:0]               merged;
    logic [31:0]               shifted;
    logic [3:0]                fwd_hit;
    logic [3:0]                load_mask;
    logic [1:0]                lane;
    logic                      is_store;
    logic                      load_hit;
    logic                      taken;
    way_idx_t                  victim_q;
    way_idx_t                  cm_way_q;

    assign req = m1.m1_req;
    assign is_store = |req.strb;

    // tag compare, port 1 wins when the commit side hit the same index
    always_comb begin
        ram_word = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            tag_sel[w] = req.tag_conflict ? tag_rdata1_i[w] : tag_rdata0_i[w];
            tag_hit[w] = tag_sel[w].valid && (tag_sel[w].tag == req.addr[31:`DC_TAG_LO]);
            if (tag_hit[w]) begin
                ram_word = req.data_conflict ? data_rdata1_i[w] : data_rdata0_i[w];
            end
        end
    end

    // oldest first, so the youngest matching store ends up on top
    always_comb begin
        fwd_hit = '0;
        fwd_word = '0;
        for (int e = 0; e < `DC_SB_DEPTH; e++) begin
            for (int b = 0; b < 4; b++) begin
                if (sb.entries[e].valid && sb.entries[e].strb[b]
                    && (sb.entries[e].addr == req.addr[31:2])) begin
                    fwd_hit[b] = 1'b1;
                    fwd_word[8*b +: 8] = sb.entries[e].data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_hit[b] ? fwd_word[8*b +: 8] : ram_word[8*b +: 8];
        end
    end

    // bytes a load needs and where they start
    always_comb begin
        lane = 2'd0;
        load_mask = 4'b1111;
        if (req.size == MEM_BYTE) begin
            lane = req.addr[1:0];
            load_mask = 4'b0001 << lane;
        end else if (req.size == MEM_HALF) begin
            lane = {req.addr[1], 1'b0};
            load_mask = 4'b0011 << lane;
        end
    end

    assign load_hit = (load_mask & ({4{|tag_hit}} | fwd_hit)) == load_mask;
    assign shifted = merged >> {lane, 3'b000};

    always_comb begin
        case (req.size)
            MEM_BYTE: resp_rdata_o = {{24{req.is_signed & shifted[7]}}, shifted[7:0]};
            MEM_HALF: resp_rdata_o = {{16{req.is_signed & shifted[15]}}, shifted[15:0]};
            default:  resp_rdata_o = merged;
        endcase
    end

    // a store only leaves M1 together with its push
    assign taken = m1.m1_valid && resp_ready_i && (!is_store || sb.push_ready);
    assign m1.m1_advance = !m1.m1_valid || taken;

    assign sb.push_valid = m1.m1_valid && is_store && resp_ready_i;
    always_comb begin
        sb.push_entry.valid = 1'b1;
        sb.push_entry.addr = req.addr[31:2];
        sb.push_entry.data = req.wdata;
        sb.push_entry.strb = req.strb;
        sb.push_entry.way_hit = tag_hit;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            victim_q <= '0;
            cm_way_q <= '0;
        end else begin
            cm_way_q <= cm_way_i;
            // round robin over taken load misses
            if (taken && !is_store && !load_hit) begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    assign resp_valid_o = m1.m1_valid;
    assign resp_id_o = req.id;
    assign resp_store_o = is_store;
    assign resp_hit_o = is_store ? |tag_hit : load_hit;
    assign resp_way_hit_o = tag_hit;
    assign resp_victim_o = victim_q;
    assign resp_victim_dirty_o = tag_sel[victim_q].dirty;

    // port 1 data follows cm_addr_i by one cycle
    assign cm_rdata_o = data_rdata1_i[cm_way_q];

endmodule

// File: verilog/store_buffer.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module store_buffer
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cm_sb_pop_i,
    sb_if.buffer                  sb,
    output logic                  sb_head_valid_o,
    output logic [29:0]           sb_head_addr_o,
    output logic [31:0]           sb_head_data_o,
    output logic [3:0]            sb_head_strb_o,
    output logic [`DC_WAYS-1:0]   sb_head_way_o
);

    localparam int ptr_w = $clog2(`DC_SB_DEPTH);

    sb_entry_t [`DC_SB_DEPTH-1:0] mem_q;
    logic [ptr_w-1:0]             head_q;
    logic [ptr_w-1:0]             tail_q;
    logic [ptr_w:0]               count_q;
    logic                         push;
    logic                         pop;

    assign sb.push_ready = count_q != (ptr_w + 1)'(`DC_SB_DEPTH);
    assign push = sb.push_valid && sb.push_ready;
    assign pop = cm_sb_pop_i && (count_q != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[tail_q] <= sb.push_entry;
        end
    end

    // rotate so that slot 0 is the head, valid comes from the count
    always_comb begin
        for (int i = 0; i < `DC_SB_DEPTH; i++) begin
            sb.entries[i] = mem_q[head_q + ptr_w'(i)];
            sb.entries[i].valid = (ptr_w + 1)'(i) < count_q;
        end
    end

    assign sb_head_valid_o = sb.entries[0].valid;
    assign sb_head_addr_o = sb.entries[0].addr;
    assign sb_head_data_o = sb.entries[0].data;
    assign sb_head_strb_o = sb.entries[0].strb;
    assign sb_head_way_o = sb.entries[0].way_hit;

endmodule

// File: verilog/dcache_lookup.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush_i,
    input  logic                              req_valid_i,
    output logic                              req_ready_o,
    input  logic [31:0]                       req_addr_i,
    input  logic [31:0]                       req_wdata_i,
    input  logic [3:0]                        req_strb_i,
    input  mem_size_e                         req_size_i,
    input  logic                              req_signed_i,
    input  logic [3:0]                        req_id_i,
    input  logic [31:0]                       cm_addr_i,
    output logic [`DC_IDX_HI-`DC_IDX_LO:0]    tag_raddr_o,
    output logic [`DC_IDX_HI-`DC_WORD_LO:0]   data_raddr_o,
    output logic                              tag_ren_o,
    output logic                              data_ren_o,
    m1_if.lookup                              m1
);

    logic        valid_q;
    m1_req_t     req_q;
    logic [31:0] rd_addr;
    logic        tag_conflict;
    logic        data_conflict;

    assign req_ready_o = m1.m1_advance;

    // new request on advance, else re-read the held one
    assign rd_addr = m1.m1_advance ? req_addr_i : req_q.addr;
    assign tag_raddr_o = rd_addr[`DC_IDX_HI:`DC_IDX_LO];
    assign data_raddr_o = rd_addr[`DC_IDX_HI:`DC_WORD_LO];

    assign tag_conflict = tag_raddr_o == cm_addr_i[`DC_IDX_HI:`DC_IDX_LO];
    assign data_conflict = data_raddr_o == cm_addr_i[`DC_IDX_HI:`DC_WORD_LO];

    // port 1 returns the same word on a conflict, port 0 can rest
    assign tag_ren_o = !tag_conflict;
    assign data_ren_o = !data_conflict;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (m1.m1_advance) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (m1.m1_advance && req_valid_i) begin
            req_q.addr <= req_addr_i;
            req_q.wdata <= req_wdata_i;
            req_q.strb <= req_strb_i;
            req_q.size <= req_size_i;
            req_q.is_signed <= req_signed_i;
            req_q.id <= req_id_i;
        end
        // follows every re-read, not only accepted requests
        req_q.tag_conflict <= tag_conflict;
        req_q.data_conflict <= data_conflict;
    end

    // flush hides M1, so the hit stage advances and the slot is refilled
    assign m1.m1_valid = valid_q && !flush_i;
    assign m1.m1_req = req_q;

endmodule

// File: verilog/dpsram.sv
`timescale 1ns/1ns

module dpsram #(
    parameter int data_width = 32,
    parameter int depth = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // port 0, read only
    input  logic [$clog2(depth)-1:0]      addr0_i,
    input  logic                          en0_i,
    output logic [data_width-1:0]         rdata0_o,
    // port 1, byte write with write-first read
    input  logic [$clog2(depth)-1:0]      addr1_i,
    input  logic [(data_width+7)/8-1:0]   we1_i,
    input  logic [data_width-1:0]         wdata1_i,
    output logic [data_width-1:0]         rdata1_o
);

    logic [data_width-1:0] mem [depth];
    logic [data_width-1:0] next1;

    // enabled bytes over the stored word, top lane may be narrower than 8
    always_comb begin
        next1 = mem[addr1_i];
        for (int b = 0; b < data_width; b++) begin
            if (we1_i[b/8]) begin
                next1[b] = wdata1_i[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|we1_i) begin
            mem[addr1_i] <= next1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata0_o <= '0;
            rdata1_o <= '0;
        end else begin
            if (en0_i) begin
                rdata0_o <= mem[addr0_i];
            end
            rdata1_o <= next1;
        end
    end

endmodule

// File: verilog/dcache_stage_if.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

// lookup stage to hit stage
interface m1_if
    import dcache_pkg::*;
();
    logic    m1_valid;
    m1_req_t m1_req;
    logic    m1_advance;

    modport lookup (output m1_valid, output m1_req, input m1_advance);
    modport hit (input m1_valid, input m1_req, output m1_advance);
endinterface

// hit stage to store buffer
interface sb_if
    import dcache_pkg::*;
();
    logic                          push_valid;
    sb_entry_t                     push_entry;
    logic                          push_ready;
    // oldest entry first
    sb_entry_t [`DC_SB_DEPTH-1:0]  entries;

    modport writer (output push_valid, output push_entry, input push_ready, input entries);
    modport buffer (input push_valid, input push_entry, output push_ready, output entries);
endinterface

// File: verilog/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef logic [$clog2(`DC_WAYS)-1:0] way_idx_t;

    // one tag sram word
    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [31:`DC_TAG_LO]  tag;
    } dc_tag_t;

    // committed store waiting to be drained
    typedef struct packed {
        logic                  valid;
        logic [29:0]           addr;
        logic [31:0]           data;
        logic [3:0]            strb;
        logic [`DC_WAYS-1:0]   way_hit;
    } sb_entry_t;

    // payload held in M1
    typedef struct packed {
        logic [31:0]           addr;
        logic [31:0]           wdata;
        logic [3:0]            strb;
        mem_size_e             size;
        logic                  is_signed;
        logic [3:0]            id;
        logic                  tag_conflict;
        logic                  data_conflict;
    } m1_req_t;

endpackage

// File: include/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_WAYS 2
`define DC_SETS 16
`define DC_LINE_WORDS 4

// store queue entries
`define DC_SB_DEPTH 4

// address fields
`define DC_IDX_LO 4
`define DC_IDX_HI 7
`define DC_TAG_LO 8
`define DC_WORD_LO 2

`endif
